// File: common/cache_pkg.sv
package cache_pkg;

   // Bus widths
   localparam int addr_w = 32;
   localparam int word_w = 32;
   localparam int line_w = 128;   // Memory bus carries a full line

   // Direct-mapped geometry
   localparam int num_lines = 16;
   localparam int index_w   = 4;
   localparam int offset_w  = 4;  // Byte offset within a line
   localparam int tag_w     = 24;

   typedef logic [addr_w-1:0]  addr_t;
   typedef logic [word_w-1:0]  word_t;
   typedef logic [line_w-1:0]  line_t;
   typedef logic [tag_w-1:0]   tag_t;
   typedef logic [index_w-1:0] index_t;

   // CPU side, one-cycle strobe
   typedef struct packed {
      logic  req;
      logic  write;
      logic  is_byte;
      addr_t addr;
      word_t wdata;
   } cache_req_t;

   typedef struct packed {
      logic  valid;   // One pulse per request
      word_t rdata;
   } cache_resp_t;

   // Cache to arbiter, req held until ack
   typedef struct packed {
      logic  req;
      logic  write;
      addr_t addr;    // Line aligned
      line_t wline;
   } mem_req_t;

   typedef struct packed {
      logic  ack;
      line_t rline;
   } mem_resp_t;

   // Per-cache controller
   typedef enum logic [1:0] {
      idle,
      lookup,
      fill,
      write_through
   } ctrl_state_t;

endpackage

// File: cache/cache_store.sv
module cache_store (
   input  logic             clk,
   input  logic             if_id_reset,
   input  cache_pkg::addr_t addr,
   input  logic             is_byte,
   input  cache_pkg::word_t wdata,
   input  logic             fill,
   input  cache_pkg::line_t fill_line,
   input  logic             merge,
   output logic             hit,
   output cache_pkg::word_t rdata,
   output cache_pkg::line_t line
);
   import cache_pkg::*;

   // Tag, valid and data arrays
   tag_t                 tag_mem  [num_lines];
   line_t                data_mem [num_lines];
   logic [num_lines-1:0] valid;

   index_t              index;
   tag_t                tag;
   logic [offset_w-1:0] byte_sel;
   logic [1:0]          word_sel;
   logic [6:0]          byte_bit;
   logic [6:0]          word_bit;
   line_t               cur_line;
   line_t               merged;
   logic [7:0]          byte_lane;

   // Address split
   assign tag      = addr[addr_w-1 -: tag_w];
   assign index    = addr[offset_w +: index_w];
   assign byte_sel = addr[offset_w-1:0];
   assign word_sel = addr[offset_w-1:2];

   // Bit position of the addressed lane
   assign byte_bit = {byte_sel, 3'b000};
   assign word_bit = {word_sel, 5'b00000};

   assign cur_line = data_mem[index];
   assign hit      = valid[index] && (tag_mem[index] == tag);

   // Read side
   assign byte_lane = cur_line[byte_bit +: 8];

   always_comb begin
      if (is_byte) begin
         rdata = {{(word_w-8){1'b0}}, byte_lane};   // Zero-extended
      end else begin
         rdata = cur_line[word_bit +: word_w];
      end
   end

   // Store data merged into the current line
   always_comb begin
      merged = cur_line;
      if (is_byte) begin
         merged[byte_bit +: 8] = wdata[7:0];
      end else begin
         merged[word_bit +: word_w] = wdata;
      end
   end

   // Same line goes out on the write-through
   assign line = merged;

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         valid <= '0;
      end else if (fill) begin
         valid[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill) begin
         tag_mem[index]  <= tag;
         data_mem[index] <= fill_line;   // Line from memory
      end else if (merge) begin
         data_mem[index] <= merged;
      end
   end

endmodule

// File: cache/cache_ctrl.sv
module cache_ctrl (
   input  logic                   clk,
   input  logic                   if_id_reset,
   input  cache_pkg::cache_req_t  cpu_req,
   output cache_pkg::cache_resp_t cpu_resp,
   output cache_pkg::mem_req_t    mem_req,
   input  cache_pkg::mem_resp_t   mem_resp
);
   import cache_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   cache_req_t  req_q;

   logic  hit;
   logic  wt_done;
   logic  store_fill;
   logic  store_merge;
   word_t store_rdata;
   line_t store_line;

   cache_store i_store (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .addr        (req_q.addr),
      .is_byte     (req_q.is_byte),
      .wdata       (req_q.wdata),
      .fill        (store_fill),
      .fill_line   (mem_resp.rline),
      .merge       (store_merge),
      .hit         (hit),
      .rdata       (store_rdata),
      .line        (store_line)
   );

   // Request is captured on the strobe and held until the answer
   always_ff @(posedge clk) begin
      if (state == idle && cpu_req.req) begin
         req_q <= cpu_req;
      end
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         state <= idle;
      end else begin
         state <= state_nxt;
      end
   end

   // Write answer comes one cycle after the memory ack
   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         wt_done <= 1'b0;
      end else begin
         wt_done <= (state == write_through) && mem_resp.ack;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         idle: begin
            if (cpu_req.req) begin
               state_nxt = lookup;
            end
         end
         lookup: begin
            if (!hit) begin
               state_nxt = fill;
            end else if (req_q.write) begin
               state_nxt = write_through;   // Merged this cycle
            end else begin
               state_nxt = idle;
            end
         end
         fill: begin
            // Back to lookup, which now hits on the installed line
            if (mem_resp.ack) begin
               state_nxt = lookup;
            end
         end
         write_through: begin
            if (mem_resp.ack) begin
               state_nxt = idle;
            end
         end
         default: state_nxt = idle;
      endcase
   end

   assign store_fill  = (state == fill) && mem_resp.ack;
   assign store_merge = (state == lookup) && hit && req_q.write;

   // Line-aligned memory request
   always_comb begin
      mem_req.req   = (state == fill) || (state == write_through);
      mem_req.write = (state == write_through);
      mem_req.addr  = {req_q.addr[addr_w-1:offset_w], {offset_w{1'b0}}};
      mem_req.wline = store_line;
   end

   always_comb begin
      cpu_resp.valid = ((state == lookup) && hit && !req_q.write) || wt_done;
      cpu_resp.rdata = store_rdata;   // Word or zero-extended byte
   end

endmodule

// File: design/mem_arbiter.sv
module mem_arbiter (
   input  logic                 clk,
   input  logic                 if_id_reset,
   input  cache_pkg::mem_req_t  fetch_mem_req,
   output cache_pkg::mem_resp_t fetch_mem_resp,
   input  cache_pkg::mem_req_t  data_mem_req,
   output cache_pkg::mem_resp_t data_mem_resp,
   output logic                 mem_enable,
   output logic                 mem_rw,
   output cache_pkg::addr_t     mem_addr,
   output cache_pkg::line_t     mem_data_in,
   input  cache_pkg::line_t     mem_data_out,
   input  logic                 mem_ack
);
   import cache_pkg::*;

   logic     busy;       // Bus owned by a client
   logic     gnt_data;   // 1 data cache, 0 fetch cache
   logic     start;
   logic     start_data;
   mem_req_t granted;

   // Fixed priority, data cache first
   assign start      = !busy && (data_mem_req.req || fetch_mem_req.req);
   assign start_data = data_mem_req.req;

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         busy     <= 1'b0;
         gnt_data <= 1'b0;
      end else if (start) begin
         busy     <= 1'b1;
         gnt_data <= start_data;
      end else if (busy && mem_ack) begin
         busy <= 1'b0;   // Enable drops the cycle after ack
      end
   end

   // Granted client drives the bus
   always_comb begin
      if (gnt_data) begin
         granted = data_mem_req;
      end else begin
         granted = fetch_mem_req;
      end
   end

   always_comb begin
      mem_enable  = busy;
      mem_rw      = granted.write;
      mem_addr    = granted.addr;
      mem_data_in = granted.wline;
   end

   // Reply goes back to the owner in the ack cycle
   always_comb begin
      data_mem_resp.ack    = busy && gnt_data && mem_ack;
      data_mem_resp.rline  = mem_data_out;
      fetch_mem_resp.ack   = busy && !gnt_data && mem_ack;
      fetch_mem_resp.rline = mem_data_out;
   end

endmodule

// File: design/cache_hierarchy.sv
module cache_hierarchy (
   input  logic                   clk,
   input  logic                   if_id_reset,
   input  cache_pkg::cache_req_t  fetch_req,
   output cache_pkg::cache_resp_t fetch_resp,
   input  cache_pkg::cache_req_t  data_req,
   output cache_pkg::cache_resp_t data_resp,
   output logic                   mem_enable,
   output logic                   mem_rw,
   output cache_pkg::addr_t       mem_addr,
   output cache_pkg::line_t       mem_data_in,
   input  cache_pkg::line_t       mem_data_out,
   input  logic                   mem_ack
);
   import cache_pkg::*;

   mem_req_t  ic_mem_req;
   mem_resp_t ic_mem_resp;
   mem_req_t  dc_mem_req;
   mem_resp_t dc_mem_resp;

   // Instruction side, also used by a program loader
   cache_ctrl i_icache (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .cpu_req     (fetch_req),
      .cpu_resp    (fetch_resp),
      .mem_req     (ic_mem_req),
      .mem_resp    (ic_mem_resp)
   );

   cache_ctrl i_dcache (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .cpu_req     (data_req),
      .cpu_resp    (data_resp),
      .mem_req     (dc_mem_req),
      .mem_resp    (dc_mem_resp)
   );

   mem_arbiter i_arbiter (
      .clk            (clk),
      .if_id_reset    (if_id_reset),
      .fetch_mem_req  (ic_mem_req),
      .fetch_mem_resp (ic_mem_resp),
      .data_mem_req   (dc_mem_req),
      .data_mem_resp  (dc_mem_resp),
      .mem_enable     (mem_enable),
      .mem_rw         (mem_rw),
      .mem_addr       (mem_addr),
      .mem_data_in    (mem_data_in),
      .mem_data_out   (mem_data_out),
      .mem_ack        (mem_ack)
   );

endmodule

// File: tb/mem_model.sv
module mem_model (
   input  logic             clk,
   input  logic             if_id_reset,
   input  logic             mem_enable,
   input  logic             mem_rw,
   input  cache_pkg::addr_t mem_addr,
   input  cache_pkg::line_t mem_data_in,
   output cache_pkg::line_t mem_data_out,
   output logic             mem_ack
);
   timeunit 1ns;
   timeprecision 1ps;
   import cache_pkg::*;

   localparam int mem_lines = 256;   // 4 KB window
   localparam int ack_delay = 3;

   line_t      mem [mem_lines];
   logic [7:0] line_idx;
   int         ack_cnt;

   assign line_idx = mem_addr[offset_w +: 8];

   // Each word holds its own byte address XOR a fixed pattern
   initial begin
      addr_t a;
      for (int i = 0; i < mem_lines; i++) begin
         for (int w = 0; w < 4; w++) begin
            a = (i * 16) + (w * 4);
            mem[i][w*word_w +: word_w] = a ^ 32'h5a5a_0000;
         end
      end
   end

   always @(posedge clk) begin
      if (if_id_reset) begin
         mem_ack      <= 1'b0;
         mem_data_out <= '0;
         ack_cnt      <= 0;
      end else if (mem_ack) begin
         mem_ack <= 1'b0;   // One-cycle ack
         ack_cnt <= 0;
      end else if (mem_enable) begin
         if (ack_cnt == ack_delay - 1) begin
            mem_ack <= 1'b1;
            if (mem_rw) begin
               mem[line_idx] <= mem_data_in;
            end else begin
               mem_data_out <= mem[line_idx];
            end
            ack_cnt <= 0;
         end else begin
            ack_cnt <= ack_cnt + 1;
         end
      end
   end

endmodule

// File: tb/cache_hierarchy_assert.sv
module cache_hierarchy_assert (
   input logic             clk,
   input logic             if_id_reset,
   input logic             mem_enable,
   input logic             mem_rw,
   input cache_pkg::addr_t mem_addr,
   input logic             mem_ack
);
   timeunit 1ns;
   timeprecision 1ps;

   int error_count = 0;   // Failures so far, polled by the testbench

   // Enable held until the memory answers
   enable_held: assert property (@(posedge clk) disable iff (if_id_reset)
      mem_enable && !mem_ack |=> mem_enable)
      else begin
         error_count++;
         $error("mem_enable dropped before mem_ack");
      end

   bus_stable: assert property (@(posedge clk) disable iff (if_id_reset)
      mem_enable && $past(mem_enable) |-> $stable(mem_addr) && $stable(mem_rw))
      else begin
         error_count++;
         $error("mem_addr or mem_rw changed during a memory cycle");
      end

   ack_needs_enable: assert property (@(posedge clk) disable iff (if_id_reset)
      mem_ack |-> mem_enable)
      else begin
         error_count++;
         $error("mem_ack without mem_enable");
      end

endmodule

bind mem_arbiter cache_hierarchy_assert i_bus_assert (
   .clk         (clk),
   .if_id_reset (if_id_reset),
   .mem_enable  (mem_enable),
   .mem_rw      (mem_rw),
   .mem_addr    (mem_addr),
   .mem_ack     (mem_ack)
);

// File: tb/cache_hierarchy_tb.sv
module cache_hierarchy_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import cache_pkg::*;

   localparam int resp_timeout = 50;

   logic        clk;
   logic        if_id_reset;
   cache_req_t  fetch_req;
   cache_req_t  data_req;
   cache_resp_t fetch_resp;
   cache_resp_t data_resp;
   logic        mem_enable;
   logic        mem_rw;
   addr_t       mem_addr;
   line_t       mem_data_in;
   line_t       mem_data_out;
   logic        mem_ack;

   integer seed;
   logic   bus_active;
   addr_t  bus_addr_q[$];   // One entry per memory cycle
   logic   bus_rw_q[$];
   line_t  bus_wline_q[$];

   cache_hierarchy i_cache_hierarchy (
      .clk          (clk),
      .if_id_reset  (if_id_reset),
      .fetch_req    (fetch_req),
      .fetch_resp   (fetch_resp),
      .data_req     (data_req),
      .data_resp    (data_resp),
      .mem_enable   (mem_enable),
      .mem_rw       (mem_rw),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_data_out (mem_data_out),
      .mem_ack      (mem_ack)
   );

   mem_model i_mem (
      .clk          (clk),
      .if_id_reset  (if_id_reset),
      .mem_enable   (mem_enable),
      .mem_rw       (mem_rw),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_data_out (mem_data_out),
      .mem_ack      (mem_ack)
   );

   always #5 clk = ~clk;

   // Log a memory cycle when enable rises
   always @(negedge clk) begin
      if (mem_enable && !bus_active) begin
         bus_addr_q.push_back(mem_addr);
         bus_rw_q.push_back(mem_rw);
         bus_wline_q.push_back(mem_data_in);
      end
      bus_active = mem_enable;
   end

   // Stop at the first bus protocol violation
   always @(negedge clk) begin
      if (i_cache_hierarchy.i_arbiter.i_bus_assert.error_count != 0) begin
         abort_run("The memory bus protocol was violated");
      end
   end

   task automatic check_value(input string name, input logic [line_w-1:0] got,
                              input logic [line_w-1:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1);
   endtask

   // Bit 11 picks the port region, bits 10:8 the tag group of a test
   function automatic addr_t pick_addr(input logic side, input logic [2:0] tag_sel);
      logic [31:0] r;
      r = $random(seed);
      return {20'h0, side, tag_sel, r[7:4], r[3:2], 2'b00};
   endfunction

   function automatic addr_t line_base(input addr_t a);
      return {a[addr_w-1:offset_w], {offset_w{1'b0}}};
   endfunction

   function automatic word_t pattern_word(input addr_t a);
      return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
   endfunction

   function automatic line_t model_line(input addr_t a);
      return i_mem.mem[a[11:4]];
   endfunction

   function automatic word_t lane_word(input line_t l, input addr_t a);
      return l[a[3:2]*word_w +: word_w];
   endfunction

   function automatic line_t merge_store(input line_t l, input addr_t a,
                                         input logic is_byte, input word_t d);
      line_t m;
      m = l;
      if (is_byte) begin
         m[a[3:0]*8 +: 8] = d[7:0];
      end else begin
         m[a[3:2]*word_w +: word_w] = d;
      end
      return m;
   endfunction

   function automatic string port_name(input logic port);
      return port ? "data_resp" : "fetch_resp";
   endfunction

   task automatic clear_log();
      bus_addr_q.delete();
      bus_rw_q.delete();
      bus_wline_q.delete();
   endtask

   task automatic drive_req(input logic port, input logic write, input logic is_byte,
                            input addr_t addr, input word_t wdata);
      cache_req_t r;
      r = {1'b1, write, is_byte, addr, wdata};
      if (port) begin
         data_req = r;
      end else begin
         fetch_req = r;
      end
   endtask

   task automatic release_reqs();
      fetch_req.req = 1'b0;
      data_req.req  = 1'b0;
   endtask

   // Starts one cycle after the strobe, lat counts from the strobe
   task automatic wait_resp(input logic port, output word_t rdata, output int lat);
      cache_resp_t resp;
      lat  = 1;
      resp = port ? data_resp : fetch_resp;
      while (!resp.valid) begin
         if (lat >= resp_timeout) begin
            abort_run({"Timeout waiting for a valid pulse on ", port_name(port)});
         end
         @(negedge clk);
         lat++;
         resp = port ? data_resp : fetch_resp;
      end
      rdata = resp.rdata;
      @(negedge clk);
      resp = port ? data_resp : fetch_resp;
      check_value({port_name(port), ".valid"}, resp.valid, 1'b0);   // Single pulse
   endtask

   task automatic access(input logic port, input logic write, input logic is_byte,
                         input addr_t addr, input word_t wdata,
                         output word_t rdata, output int lat);
      @(negedge clk);
      drive_req(port, write, is_byte, addr, wdata);
      @(negedge clk);
      release_reqs();
      wait_resp(port, rdata, lat);
   endtask

   task automatic expect_miss_read(input logic port, input addr_t a, input word_t exp);
      word_t rdata;
      int    lat;
      clear_log();
      access(port, 1'b0, 1'b0, a, '0, rdata, lat);
      check_value({port_name(port), ".rdata"}, rdata, exp);
      check_value("memory cycle count", bus_addr_q.size(), 1);
      check_value("mem_addr", bus_addr_q[0], line_base(a));
      check_value("mem_rw", bus_rw_q[0], 1'b0);
   endtask

   task automatic test_cold_miss(output addr_t fa, output addr_t da);
      fa = pick_addr(1'b0, 3'd0);
      da = pick_addr(1'b1, 3'd0);
      expect_miss_read(1'b0, fa, pattern_word(fa));
      expect_miss_read(1'b1, da, pattern_word(da));
   endtask

   task automatic test_hit_latency(input addr_t fa, input addr_t da);
      addr_t a;
      word_t rdata;
      int    lat;
      for (int port = 0; port < 2; port++) begin
         a = port ? da : fa;
         a = line_base(a) | ((a + 4) & 32'hc);   // Next word, same line
         clear_log();
         access(port[0], 1'b0, 1'b0, a, '0, rdata, lat);
         check_value("hit latency", lat, 1);
         check_value({port_name(port[0]), ".rdata"}, rdata, pattern_word(a));
         check_value("memory cycle count", bus_addr_q.size(), 0);
      end
   endtask

   task automatic test_write_merge(input addr_t da);
      addr_t wa;
      addr_t ba;
      word_t wdata;
      word_t rdata;
      line_t exp_line;
      int    lat;
      // Word write that hits
      wa       = line_base(da) | 32'h8;
      wdata    = $random(seed);
      exp_line = merge_store(model_line(wa), wa, 1'b0, wdata);
      clear_log();
      access(1'b1, 1'b1, 1'b0, wa, wdata, rdata, lat);
      check_value("memory cycle count", bus_addr_q.size(), 1);
      check_value("mem_rw", bus_rw_q[0], 1'b1);
      check_value("mem_addr", bus_addr_q[0], line_base(wa));
      check_value("mem_data_in", bus_wline_q[0], exp_line);
      access(1'b1, 1'b0, 1'b0, wa, '0, rdata, lat);
      check_value("data_resp.rdata", rdata, wdata);
      // Byte write that misses, fill then write-through
      ba       = pick_addr(1'b1, 3'd1) | 32'h3;
      wdata    = $random(seed);
      exp_line = merge_store(model_line(ba), ba, 1'b1, wdata);
      clear_log();
      access(1'b1, 1'b1, 1'b1, ba, wdata, rdata, lat);
      check_value("memory cycle count", bus_addr_q.size(), 2);
      check_value("mem_rw", bus_rw_q[0], 1'b0);
      check_value("mem_rw", bus_rw_q[1], 1'b1);
      check_value("mem_addr", bus_addr_q[1], line_base(ba));
      check_value("mem_data_in", bus_wline_q[1], exp_line);
      check_value("memory line", model_line(ba), exp_line);
      access(1'b1, 1'b0, 1'b0, {ba[31:2], 2'b00}, '0, rdata, lat);
      check_value("data_resp.rdata", rdata, lane_word(exp_line, ba));
   endtask

   task automatic test_byte_lanes();
      addr_t a;
      word_t w;
      word_t exp;
      word_t rdata;
      int    lat;
      a = pick_addr(1'b1, 3'd2);
      w = pattern_word(a);
      for (int lane = 0; lane < 4; lane++) begin
         exp = (w >> (lane * 8)) & 32'hff;
         access(1'b1, 1'b0, 1'b1, a + lane, '0, rdata, lat);
         check_value("data_resp.rdata", rdata, exp);
      end
   endtask

   task automatic test_dual_miss();
      addr_t fa;
      addr_t da;
      word_t f_rdata;
      word_t d_rdata;
      int    lat;
      fa = pick_addr(1'b0, 3'd3);
      da = pick_addr(1'b1, 3'd3);
      clear_log();
      @(negedge clk);
      drive_req(1'b0, 1'b0, 1'b0, fa, '0);
      drive_req(1'b1, 1'b0, 1'b0, da, '0);
      @(negedge clk);
      release_reqs();
      wait_resp(1'b1, d_rdata, lat);   // Data side is granted first
      wait_resp(1'b0, f_rdata, lat);
      check_value("memory cycle count", bus_addr_q.size(), 2);
      check_value("mem_addr", bus_addr_q[0], line_base(da));
      check_value("mem_addr", bus_addr_q[1], line_base(fa));
      check_value("data_resp.rdata", d_rdata, pattern_word(da));
      check_value("fetch_resp.rdata", f_rdata, pattern_word(fa));
   endtask

   task automatic test_evict();
      addr_t a1;
      addr_t a2;
      a1 = pick_addr(1'b1, 3'd4);
      a2 = {a1[31:11], 3'd5, a1[7:0]};   // Same index, other tag
      expect_miss_read(1'b1, a1, pattern_word(a1));
      expect_miss_read(1'b1, a2, pattern_word(a2));
      expect_miss_read(1'b1, a1, pattern_word(a1));
   endtask

   initial begin
      addr_t fa;
      addr_t da;
      seed        = 32'ha5cf_7107;
      clk         = 1'b0;
      if_id_reset = 1'b1;
      fetch_req   = '0;
      data_req    = '0;
      bus_active  = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      if_id_reset = 1'b0;
      check_value("fetch_resp.valid", fetch_resp.valid, 1'b0);
      check_value("data_resp.valid", data_resp.valid, 1'b0);
      check_value("mem_enable", mem_enable, 1'b0);
      test_cold_miss(fa, da);
      test_hit_latency(fa, da);
      test_write_merge(da);
      test_byte_lanes();
      test_dual_miss();
      test_evict();
      if (i_cache_hierarchy.i_arbiter.i_bus_assert.error_count != 0) begin
         abort_run("The memory bus protocol was violated");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

// File: src.f
common/cache_pkg.sv
cache/cache_store.sv
cache/cache_ctrl.sv
design/mem_arbiter.sv
design/cache_hierarchy.sv
tb/mem_model.sv
tb/cache_hierarchy_assert.sv
tb/cache_hierarchy_tb.sv
